/* flist.f */
+incdir+include
source/eth_pkg.sv
source/arp_pkg.sv
source/arp_frame_queue.sv
source/arp_frame_serializer.sv
source/stream_skid_buffer.sv
source/arp_eth_tx_top.sv
testbench/arp_eth_tx_chk.sv
testbench/arp_eth_tx_tb.sv

/* include/arp_macros.svh */
`ifndef ARP_MACROS_SVH
`define ARP_MACROS_SVH

// ethertype carried in the Ethernet header of every ARP frame
`define ETH_TYPE_ARP 16'h0806

// hardware and protocol address lengths for Ethernet/IPv4
`define ARP_HLEN 8'd6
`define ARP_PLEN 8'd4

// 28 payload bytes fit into four 64-bit words
`define ARP_PAYLOAD_WORDS 4

// default number of whole frames waiting ahead of the serializer
`define ARP_QUEUE_DEPTH 4

`endif

/* source/arp_eth_tx_top.sv */
`timescale 1ns/10ps

module arp_eth_tx_top (
    input  logic                clk,
    input  logic                rst,

    input  logic                frame_valid,
    output logic                frame_ready,
    input  arp_pkg::arp_frame_t frame,

    output logic                hdr_valid,
    input  logic                hdr_ready,
    output eth_pkg::eth_hdr_t   hdr,

    output logic                word_valid,
    input  logic                word_ready,
    output eth_pkg::eth_word_t  word,

    output logic                busy
);

    logic                q_valid;
    logic                q_ready;
    arp_pkg::arp_frame_t q_frame;

    // serializer to skid buffers
    logic                ser_hdr_valid;
    logic                ser_hdr_ready;
    eth_pkg::eth_hdr_t   ser_hdr;
    logic                ser_word_valid;
    logic                ser_word_ready;
    eth_pkg::eth_word_t  ser_word;

    logic                ser_active;
    logic                hdr_occupied;
    logic                word_occupied;

    arp_frame_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (frame_valid),
        .in_ready  (frame_ready),
        .in_frame  (frame),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out_frame (q_frame)
    );

    arp_frame_serializer u_serializer (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (q_valid),
        .in_ready   (q_ready),
        .in_frame   (q_frame),
        .hdr_valid  (ser_hdr_valid),
        .hdr_ready  (ser_hdr_ready),
        .hdr        (ser_hdr),
        .word_valid (ser_word_valid),
        .word_ready (ser_word_ready),
        .word       (ser_word),
        .active     (ser_active)
    );

    stream_skid_buffer #(
        .payload_t (eth_pkg::eth_hdr_t)
    ) u_hdr_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ser_hdr_valid),
        .in_ready  (ser_hdr_ready),
        .in_data   (ser_hdr),
        .out_valid (hdr_valid),
        .out_ready (hdr_ready),
        .out_data  (hdr),
        .occupied  (hdr_occupied)
    );

    stream_skid_buffer #(
        .payload_t (eth_pkg::eth_word_t)
    ) u_word_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ser_word_valid),
        .in_ready  (ser_word_ready),
        .in_data   (ser_word),
        .out_valid (word_valid),
        .out_ready (word_ready),
        .out_data  (word),
        .occupied  (word_occupied)
    );

    // queued frames alone do not count as busy
    assign busy = ser_active || hdr_occupied || word_occupied;

endmodule

/* source/arp_frame_queue.sv */
`timescale 1ns/10ps

`include "arp_macros.svh"

module arp_frame_queue #(
    parameter int DEPTH = `ARP_QUEUE_DEPTH
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               in_valid,
    output logic               in_ready,
    input  arp_pkg::arp_frame_t in_frame,

    output logic               out_valid,
    input  logic               out_ready,
    output arp_pkg::arp_frame_t out_frame
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // frame storage
    arp_pkg::arp_frame_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_frame = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_frame;
        end
    end

endmodule

/* source/arp_frame_serializer.sv */
`timescale 1ns/10ps

`include "arp_macros.svh"

module arp_frame_serializer (
    input  logic                clk,
    input  logic                rst,

    input  logic                in_valid,
    output logic                in_ready,
    input  arp_pkg::arp_frame_t in_frame,

    output logic                hdr_valid,
    input  logic                hdr_ready,
    output eth_pkg::eth_hdr_t   hdr,

    output logic                word_valid,
    input  logic                word_ready,
    output eth_pkg::eth_word_t  word,

    output logic                active
);

    localparam int IDX_W = $clog2(`ARP_PAYLOAD_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`ARP_PAYLOAD_WORDS - 1);

    // frame held for the whole serialization
    arp_pkg::arp_frame_t frame_reg;

    logic             hdr_pending;
    logic             word_pending;
    logic [IDX_W-1:0] word_idx;

    logic             in_xfer;
    logic             hdr_xfer;
    logic             word_xfer;
    logic             word_last;
    logic [63:0]      net_seq;

    // turn a sequence with the first wire byte in the msb into
    // stream order with the first wire byte in data[7:0]
    function automatic logic [63:0] net_to_wire(input logic [63:0] seq);
        logic [63:0] res;
        for (int i = 0; i < 8; i++) begin
            res[i*8 +: 8] = seq[(7-i)*8 +: 8];
        end
        return res;
    endfunction

    assign active   = hdr_pending || word_pending;
    assign in_ready = !active;

    assign in_xfer   = in_valid && in_ready;
    assign hdr_xfer  = hdr_valid && hdr_ready;
    assign word_xfer = word_valid && word_ready;

    assign hdr_valid     = hdr_pending;
    assign hdr.dest_mac  = frame_reg.dest_mac;
    assign hdr.src_mac   = frame_reg.src_mac;
    assign hdr.eth_type  = `ETH_TYPE_ARP;

    assign word_valid = word_pending;
    assign word_last  = (word_idx == LAST_IDX);

    // payload bytes of the current word, first wire byte in the msb
    always_comb begin
        case (word_idx)
            0: net_seq = {frame_reg.htype, frame_reg.ptype, `ARP_HLEN, `ARP_PLEN,
                          frame_reg.oper};
            1: net_seq = {frame_reg.sha, frame_reg.spa[31:16]};
            2: net_seq = {frame_reg.spa[15:0], frame_reg.tha};
            // tpa followed by four zero bytes
            default: net_seq = {frame_reg.tpa, 32'h0};
        endcase
    end

    assign word.data = net_to_wire(net_seq);
    assign word.keep = word_last ? 8'h0f : 8'hff;
    assign word.last = word_last;
    assign word.user = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_pending  <= 1'b0;
            word_pending <= 1'b0;
            word_idx     <= '0;
        end else if (in_xfer) begin
            hdr_pending  <= 1'b1;
            word_pending <= 1'b1;
            word_idx     <= '0;
        end else begin
            if (hdr_xfer) begin
                hdr_pending <= 1'b0;
            end
            // header and words drain independently
            if (word_xfer) begin
                if (word_last) begin
                    word_pending <= 1'b0;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            frame_reg <= in_frame;
        end
    end

endmodule

/* source/arp_pkg.sv */
package arp_pkg;

    // parallel ARP request or reply
    // ethertype, hlen and plen are fixed and added by the serializer
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [15:0] oper;
        // sender hardware and protocol address
        logic [47:0] sha;
        logic [31:0] spa;
        // target hardware and protocol address
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_frame_t;

endpackage

/* source/eth_pkg.sv */
package eth_pkg;

    // Ethernet header, fields in transmit order
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one beat of the 64-bit payload stream
    // byte 0 sits in data[7:0] and goes out first
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } eth_word_t;

endpackage

/* source/stream_skid_buffer.sv */
`timescale 1ns/10ps

module stream_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data,

    output logic     occupied
);

    // output register and temporary register
    payload_t out_data_reg;
    payload_t temp_data_reg;
    logic     out_valid_reg;
    logic     temp_valid_reg;
    logic     in_ready_reg;

    logic     in_xfer;
    logic     out_valid_next;
    logic     temp_valid_next;
    logic     load_out_from_in;
    logic     load_out_from_temp;
    logic     load_temp;

    assign in_ready  = in_ready_reg;
    assign out_valid = out_valid_reg;
    assign out_data  = out_data_reg;
    assign occupied  = out_valid_reg || temp_valid_reg;

    assign in_xfer = in_valid && in_ready_reg;

    always_comb begin
        out_valid_next     = out_valid_reg;
        temp_valid_next    = temp_valid_reg;
        load_out_from_in   = 1'b0;
        load_out_from_temp = 1'b0;
        load_temp          = 1'b0;

        if (in_xfer) begin
            if (out_ready || !out_valid_reg) begin
                // output free or draining this cycle
                out_valid_next   = 1'b1;
                load_out_from_in = 1'b1;
            end else begin
                // stalled, park the item
                temp_valid_next = 1'b1;
                load_temp       = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next     = temp_valid_reg;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
            in_ready_reg   <= 1'b1;
        end else begin
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            // accept again once the temp slot is free
            in_ready_reg   <= !temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_data_reg <= in_data;
        end else if (load_out_from_temp) begin
            out_data_reg <= temp_data_reg;
        end
        if (load_temp) begin
            temp_data_reg <= in_data;
        end
    end

endmodule

/* testbench/arp_eth_tx_cases.txt */
# dest_mac src_mac htype ptype oper sha spa tha tpa
# one ARP frame per line, hexadecimal without prefix
ffffffffffff 02a1b2c3d4e5 0001 0800 0001 02a1b2c3d4e5 c0a80001 000000000000 c0a80002
02a1b2c3d4e5 0a1b2c3d4e5f 0001 0800 0002 0a1b2c3d4e5f c0a80002 02a1b2c3d4e5 c0a80001
ffffffffffff 3c52829a0f11 0001 0800 0001 3c52829a0f11 0a000105 000000000000 0a0001fe
3c52829a0f11 b827eb4455aa 0001 0800 0002 b827eb4455aa 0a0001fe 3c52829a0f11 0a000105
ffffffffffff 001122334455 0001 0800 0001 001122334455 ac100a0b 000000000000 ac100a0b
7e8f90a1b2c3 d4e5f6071829 0006 86dd 0003 d4e5f6071829 deadbeef 7e8f90a1b2c3 01020304
ffffffffffff 5a5a5a5a5a5a 0001 0800 0001 a5a5a5a5a5a5 ffffffff 5a5a5a5a5a5a 00000000
0123456789ab fedcba987654 8001 0800 0002 13579bdf2468 87654321 eca8642fdb97 12345678

/* testbench/arp_eth_tx_chk.sv */
`timescale 1ns/10ps

module arp_eth_tx_chk (
    input logic               clk,
    input logic               rst,
    input logic               hdr_valid,
    input logic               hdr_ready,
    input eth_pkg::eth_hdr_t  hdr,
    input logic               word_valid,
    input logic               word_ready,
    input eth_pkg::eth_word_t word
);

    int unsigned fail_count = 0;

    // a stalled item waits unchanged
    hdr_held: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr))
        else begin
            fail_count++;
            $error("header output changed or dropped while stalled");
        end

    word_held: assert property (@(posedge clk) disable iff (rst)
        word_valid && !word_ready |=> word_valid && $stable(word))
        else begin
            fail_count++;
            $error("payload output changed or dropped while stalled");
        end

    no_valid_after_reset: assert property (@(posedge clk)
        rst |=> !hdr_valid && !word_valid)
        else begin
            fail_count++;
            $error("output valid high right after reset");
        end

    // only the final word is partial
    keep_full: assert property (@(posedge clk) disable iff (rst)
        word_valid && !word.last |-> word.keep == 8'hff)
        else begin
            fail_count++;
            $error("partial keep on a word that is not last");
        end

endmodule

bind arp_eth_tx_top arp_eth_tx_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .hdr_valid  (hdr_valid),
    .hdr_ready  (hdr_ready),
    .hdr        (hdr),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word       (word)
);

/* testbench/arp_eth_tx_tb.sv */
`timescale 1ns/10ps

module arp_eth_tx_tb;

    localparam logic [31:0] SEED = 32'h5584_f20d;
    localparam int TIMEOUT = 2000;

    logic                clk;
    logic                rst;
    logic                frame_valid;
    logic                frame_ready;
    arp_pkg::arp_frame_t frame;
    logic                hdr_valid;
    logic                hdr_ready;
    eth_pkg::eth_hdr_t   hdr;
    logic                word_valid;
    logic                word_ready;
    eth_pkg::eth_word_t  word;
    logic                busy;

    arp_pkg::arp_frame_t cases [$];
    eth_pkg::eth_hdr_t   hdr_exp [$];
    eth_pkg::eth_word_t  word_exp [$];
    logic                hold_outputs;

    arp_eth_tx_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .frame       (frame),
        .hdr_valid   (hdr_valid),
        .hdr_ready   (hdr_ready),
        .hdr         (hdr),
        .word_valid  (word_valid),
        .word_ready  (word_ready),
        .word        (word),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s (time %0t)", msg, $time);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_cases;
        int          fd;
        int          n;
        string       line;
        logic [47:0] dmac, smac, sha, tha;
        logic [15:0] htype, ptype, oper;
        logic [31:0] spa, tpa;
        fd = $fopen("testbench/arp_eth_tx_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the cases file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            dmac, smac, htype, ptype, oper, sha, spa, tha, tpa);
                if (n == 9) begin
                    cases.push_back({dmac, smac, htype, ptype, oper, sha, spa, tha, tpa});
                end
            end
        end
        $fclose(fd);
    endtask

    // expected header and payload words
    // wire byte k of the frame is seq byte k
    task automatic expect_frame(input arp_pkg::arp_frame_t f);
        logic [255:0]       seq;
        eth_pkg::eth_word_t w;
        hdr_exp.push_back({f.dest_mac, f.src_mac, 16'h0806});
        seq = {f.htype, f.ptype, 8'd6, 8'd4, f.oper, f.sha, f.spa, f.tha, f.tpa, 32'h0};
        for (int k = 0; k < 4; k++) begin
            for (int b = 0; b < 8; b++) begin
                w.data[b*8 +: 8] = seq[255 - (k*8 + b)*8 -: 8];
            end
            w.keep = (k == 3) ? 8'h0f : 8'hff;
            w.last = (k == 3);
            w.user = 1'b0;
            word_exp.push_back(w);
        end
    endtask

    // called at a falling edge
    // returns at the falling edge after the transfer
    task automatic send_frame(input arp_pkg::arp_frame_t f);
        int cycles;
        expect_frame(f);
        frame_valid = 1'b1;
        frame = f;
        cycles = 0;
        while (!frame_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_failure("timeout waiting for frame_ready");
            end
        end
        @(negedge clk);
        frame_valid = 1'b0;
    endtask

    task automatic wait_drained;
        int cycles;
        cycles = 0;
        while (hdr_exp.size() != 0 || word_exp.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_failure("timeout waiting for all headers and words to come out");
            end
        end
    endtask

    // header collector
    // ready is drawn and the transfer recorded at the falling edge
    initial begin
        logic [31:0] rnd;
        rnd = SEED ^ 32'h9e37_79b9;
        hdr_ready = 1'b0;
        forever begin
            @(negedge clk);
            rnd = xorshift32(rnd);
            hdr_ready = !rst && !hold_outputs && (rnd[1:0] != 2'b00);
            if (hdr_valid && hdr_ready) begin
                if (hdr_exp.size() == 0) begin
                    stop_with_failure("a header came out with no frame outstanding");
                end
                check_value("hdr", hdr, hdr_exp.pop_front());
            end
        end
    end

    // payload collector
    initial begin
        logic [31:0] rnd;
        rnd = SEED ^ 32'h7f4a_7c15;
        word_ready = 1'b0;
        forever begin
            @(negedge clk);
            rnd = xorshift32(rnd);
            word_ready = !rst && !hold_outputs && (rnd[1:0] != 2'b00);
            if (word_valid && word_ready) begin
                if (word_exp.size() == 0) begin
                    stop_with_failure("a payload word came out with no frame outstanding");
                end
                check_value("word", word, word_exp.pop_front());
            end
        end
    end

    // stop at the first output protocol violation seen by the checker
    always @(negedge clk) begin
        if (i_dut.u_chk.fail_count != 0) begin
            $display("an output protocol assertion failed (time %0t)", $time);
            $display("Test failed");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        logic [31:0] rnd;
        logic        saw_full;
        int          i;
        rnd = SEED;
        rst = 1'b1;
        frame_valid = 1'b0;
        frame = '0;
        hold_outputs = 1'b0;
        load_cases();
        if (cases.size() < 6) begin
            stop_with_failure("the cases file holds fewer than six frames");
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_value("frame_ready", frame_ready, 1'b1);
        check_value("hdr_valid", hdr_valid, 1'b0);
        check_value("word_valid", word_valid, 1'b0);
        check_value("busy", busy, 1'b0);

        // random back-pressure and random gaps between frames
        foreach (cases[c]) begin
            send_frame(cases[c]);
            rnd = xorshift32(rnd);
            repeat (rnd % 4) @(negedge clk);
        end
        wait_drained();

        // fill everything while both outputs are stalled
        @(posedge clk);
        hold_outputs = 1'b1;
        @(negedge clk);
        saw_full = 1'b0;
        i = 0;
        while (!saw_full && i < cases.size()) begin
            send_frame(cases[i]);
            saw_full = !frame_ready;
            i++;
        end
        if (!saw_full) begin
            stop_with_failure("frame_ready never went low while both outputs were held");
        end
        @(posedge clk);
        hold_outputs = 1'b0;
        wait_drained();
        i = 0;
        while (busy) begin
            @(negedge clk);
            i++;
            if (i > TIMEOUT) begin
                stop_with_failure("busy stayed high after the last word was accepted");
            end
        end
        check_value("hdr_valid", hdr_valid, 1'b0);
        check_value("word_valid", word_valid, 1'b0);

        if (i_dut.u_chk.fail_count != 0) begin
            $display("%0d output protocol assertions failed", i_dut.u_chk.fail_count);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
